/* tb.f */
common/lm80c_pkg.sv
src/io_decoder.sv
memory/mem_arbiter.sv
memory/ram_eraser.sv
memory/boot_checker.sv
src/audio_mixer.sv
src/lm80c_glue.sv
tb/glue_sva.sv
tb/glue_checker.sv
tb/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LM80C glue testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "All tests passed!" sim.log; then
	echo "Simulation PASS"
else
	echo "Simulation FAIL"
	exit 1
fi

/* tb/tb_top.sv */
// LM80C glue testbench
`timescale 1ns/1ps

module tb_top;
	import lm80c_pkg::*;

	// Phase lengths in clock cycles
	localparam int PH_DL     = 64;
	localparam int PH_BOOT   = 20;
	localparam int PH_RANDOM = 4000;
	localparam int ERASE_CYC = 32768;
	localparam int PH_ERASE  = ERASE_CYC + 64;
	localparam int PH_SWEEP  = 32768;
	localparam int PH_LED    = 600;
	localparam int PH_BAD    = 40;
	localparam int PH_AUDIO  = 3 * (4096 + 24);
	localparam longint TOTAL_CYC = PH_DL + PH_BOOT + PH_RANDOM + PH_ERASE + PH_SWEEP
		+ PH_LED + PH_BAD + PH_AUDIO + 16;
	localparam longint TIMEOUT_NS = (TOTAL_CYC + ERASE_CYC) * 3 / 2 * 4;

	logic CLOCK = 1'b0;
	logic reset_i;
	logic [15:0] cpu_addr, dl_addr, mem_addr;
	logic [7:0] cpu_dout, cpu_din, ctc_data, vdp_data, psg_data, dl_data;
	logic [7:0] mem_wdata, mem_rdata, chan_a, chan_b, chan_c;
	logic cpu_rd_n, cpu_wr_n, cpu_mreq_n, cpu_iorq_n, cpu_wait, cpu_reset_n;
	logic vdp_csr_n, vdp_csw_n, dl_active, dl_wr, boot_done, erase_trigger, reset_key;
	logic mem_we, mem_re, led_n, audio_l, audio_r;
	logic sig_ok, zero_check, audio_win, corrupt_sig;
	logic [7:0] mem [0:65535]; // Combinational memory model
	int seed;
	int dl_left;               // Remaining cycles of a download burst
	int errors, checks;

	always #2 CLOCK = ~CLOCK; // 4 ns period

	lm80c_glue lm80c_glue_i (
		.CLOCK(CLOCK), .reset_i(reset_i),
		.cpu_addr_i(cpu_addr), .cpu_dout_i(cpu_dout), .cpu_rd_n_i(cpu_rd_n),
		.cpu_wr_n_i(cpu_wr_n), .cpu_mreq_n_i(cpu_mreq_n), .cpu_iorq_n_i(cpu_iorq_n),
		.cpu_din_o(cpu_din), .cpu_wait_o(cpu_wait), .cpu_reset_n_o(cpu_reset_n),
		.ctc_data_i(ctc_data), .vdp_data_i(vdp_data), .psg_data_i(psg_data),
		.vdp_csr_n_o(vdp_csr_n), .vdp_csw_n_o(vdp_csw_n),
		.dl_active_i(dl_active), .dl_wr_i(dl_wr), .dl_addr_i(dl_addr), .dl_data_i(dl_data),
		.boot_done_i(boot_done), .erase_trigger_i(erase_trigger), .reset_key_i(reset_key),
		.mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_we_o(mem_we), .mem_re_o(mem_re),
		.mem_rdata_i(mem_rdata), .led_n_o(led_n),
		.chan_a_i(chan_a), .chan_b_i(chan_b), .chan_c_i(chan_c),
		.audio_l_o(audio_l), .audio_r_o(audio_r)
	);

	glue_checker glue_checker_i (
		.CLOCK(CLOCK), .reset_i(reset_i),
		.cpu_addr_i(cpu_addr), .cpu_dout_i(cpu_dout), .cpu_rd_n_i(cpu_rd_n),
		.cpu_wr_n_i(cpu_wr_n), .cpu_mreq_n_i(cpu_mreq_n), .cpu_iorq_n_i(cpu_iorq_n),
		.cpu_din_i(cpu_din), .cpu_wait_i(cpu_wait), .cpu_reset_n_i(cpu_reset_n),
		.ctc_data_i(ctc_data), .vdp_data_i(vdp_data), .psg_data_i(psg_data),
		.vdp_csr_n_i(vdp_csr_n), .vdp_csw_n_i(vdp_csw_n),
		.dl_active_i(dl_active), .dl_wr_i(dl_wr), .dl_addr_i(dl_addr), .dl_data_i(dl_data),
		.boot_done_i(boot_done), .erase_trigger_i(erase_trigger), .reset_key_i(reset_key),
		.mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata), .mem_we_i(mem_we), .mem_re_i(mem_re),
		.mem_rdata_i(mem_rdata), .led_n_i(led_n),
		.chan_a_i(chan_a), .chan_b_i(chan_b), .chan_c_i(chan_c),
		.audio_l_i(audio_l), .audio_r_i(audio_r),
		.sig_ok_i(sig_ok), .zero_check_i(zero_check), .audio_win_i(audio_win),
		.errors_o(errors), .checks_o(checks)
	);

	// Fill depends on the whole address, signature on top
	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] <= 8'(i[15:8] ^ (i[7:0] * 3) ^ 8'h5C);
		for (int k = 0; k < SIG_LEN; k++)
			mem[k] <= SIG_BYTES[(SIG_LEN-1-k)*DATA_W +: DATA_W];
	end

	assign mem_rdata = mem[mem_addr];

	always @(posedge CLOCK) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		if (corrupt_sig)
			mem[2] <= 8'h00; // Breaks third signature byte
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

	task automatic drive_idle();
		cpu_rd_n   = 1'b1;
		cpu_wr_n   = 1'b1;
		cpu_mreq_n = 1'b1;
		cpu_iorq_n = 1'b1;
	endtask

	// One random bus cycle plus peripheral and download noise
	task automatic drive_random(input bit mem_wr_ok, input bit dl_ok);
		int kind;
		kind     = $random(seed) & 7;
		cpu_addr = 16'($random(seed));
		cpu_dout = 8'($random(seed));
		ctc_data = 8'($random(seed));
		vdp_data = 8'($random(seed));
		psg_data = 8'($random(seed));
		drive_idle();
		case (kind)
			1, 2: begin
				cpu_mreq_n = 1'b0;
				cpu_rd_n   = 1'b0;
			end
			3: if (mem_wr_ok) begin
				cpu_mreq_n = 1'b0;
				cpu_wr_n   = 1'b0;
			end
			4, 5: begin
				cpu_iorq_n = 1'b0;
				cpu_rd_n   = 1'b0;
			end
			6: begin
				cpu_iorq_n = 1'b0;
				cpu_wr_n   = 1'b0;
			end
			default: ;
		endcase
		if (dl_left == 0 && dl_ok && ($random(seed) & 63) == 0)
			dl_left = 8; // Start a short burst
		dl_active = (dl_left != 0);
		dl_wr     = dl_active && ($random(seed) & 1);
		dl_addr   = 16'h0100 + (16'($random(seed)) & 16'h3FFF); // ROM area above signature
		dl_data   = 8'($random(seed));
		if (dl_left != 0)
			dl_left--;
	endtask

	task automatic run_random(input int n, input bit mem_wr_ok, input bit dl_ok);
		repeat (n) begin
			@(negedge CLOCK);
			drive_random(mem_wr_ok, dl_ok);
		end
	endtask

	task automatic run_idle(input int n);
		repeat (n) begin
			@(negedge CLOCK);
			drive_idle();
		end
	endtask

	initial begin
		seed = 32'he5340ac4;
		dl_left = 0;
		reset_i = 1'b1;
		cpu_addr = '0;
		cpu_dout = '0;
		ctc_data = '0;
		vdp_data = '0;
		psg_data = '0;
		drive_idle();
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		boot_done = 1'b0;
		erase_trigger = 1'b0;
		reset_key = 1'b0;
		chan_a = '0;
		chan_b = '0;
		chan_c = '0;
		sig_ok = 1'b1;
		zero_check = 1'b0;
		audio_win = 1'b0;
		corrupt_sig = 1'b0;
		repeat (5) @(negedge CLOCK);
		reset_i = 1'b0;
		// ROM download while the CPU is held
		dl_left = PH_DL;
		run_random(PH_DL, 1'b1, 1'b0);
		dl_active = 1'b0;
		dl_wr = 1'b0;
		boot_done = 1'b1;
		run_idle(PH_BOOT);
		run_random(PH_RANDOM, 1'b1, 1'b1);
		dl_left = 0; // No burst carried into the erase
		dl_active = 1'b0;
		dl_wr = 1'b0;
		// Erase, second edge during busy must be dropped
		@(negedge CLOCK);
		erase_trigger = 1'b1;
		run_random(10, 1'b0, 1'b0);
		erase_trigger = 1'b0;
		run_random(90, 1'b0, 1'b0);
		erase_trigger = 1'b1;
		run_random(10, 1'b0, 1'b0);
		erase_trigger = 1'b0;
		run_random(PH_ERASE - 111, 1'b0, 1'b0);
		// Read back the whole RAM half
		for (int a = 32'h8000; a <= 32'hFFFF; a++) begin
			@(negedge CLOCK);
			drive_idle();
			zero_check = 1'b1;
			cpu_addr   = 16'(a);
			cpu_mreq_n = 1'b0;
			cpu_rd_n   = 1'b0;
		end
		@(negedge CLOCK);
		zero_check = 1'b0;
		drive_idle();
		// LED port held selected, WR falls at random
		repeat (PH_LED) begin
			@(negedge CLOCK);
			drive_idle();
			cpu_addr   = 16'h0070;
			cpu_dout   = 8'($random(seed));
			cpu_iorq_n = 1'b0;
			if ($random(seed) & 1)
				cpu_wr_n = 1'b0;
		end
		// Broken signature and reset key
		@(negedge CLOCK);
		drive_idle();
		sig_ok = 1'b0;
		corrupt_sig = 1'b1;
		@(negedge CLOCK);
		corrupt_sig = 1'b0;
		reset_key = 1'b1;
		run_idle(3);
		reset_key = 1'b0;
		run_idle(PH_BAD - 5);
		// Audio, constant channels per run
		repeat (3) begin
			@(negedge CLOCK);
			chan_a = 8'($random(seed));
			chan_b = 8'($random(seed));
			chan_c = 8'($random(seed));
			run_idle(16);
			audio_win = 1'b1;
			run_idle(4096);
			audio_win = 1'b0;
			run_idle(6);
		end
		run_idle(8);
		$display("Closing: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* tb/glue_checker.sv */
// LM80C glue reference checker
`timescale 1ns/1ps

module glue_checker (
	input  logic                          CLOCK,
	input  logic                          reset_i,
	input  logic [lm80c_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] cpu_dout_i,
	input  logic                          cpu_rd_n_i,
	input  logic                          cpu_wr_n_i,
	input  logic                          cpu_mreq_n_i,
	input  logic                          cpu_iorq_n_i,
	input  logic [lm80c_pkg::DATA_W-1:0] cpu_din_i,
	input  logic                          cpu_wait_i,
	input  logic                          cpu_reset_n_i,
	input  logic [lm80c_pkg::DATA_W-1:0] ctc_data_i,
	input  logic [lm80c_pkg::DATA_W-1:0] vdp_data_i,
	input  logic [lm80c_pkg::DATA_W-1:0] psg_data_i,
	input  logic                          vdp_csr_n_i,
	input  logic                          vdp_csw_n_i,
	input  logic                          dl_active_i,
	input  logic                          dl_wr_i,
	input  logic [lm80c_pkg::ADDR_W-1:0] dl_addr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] dl_data_i,
	input  logic                          boot_done_i,
	input  logic                          erase_trigger_i,
	input  logic                          reset_key_i,
	input  logic [lm80c_pkg::ADDR_W-1:0] mem_addr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] mem_wdata_i,
	input  logic                          mem_we_i,
	input  logic                          mem_re_i,
	input  logic [lm80c_pkg::DATA_W-1:0] mem_rdata_i,
	input  logic                          led_n_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_a_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_b_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_c_i,
	input  logic                          audio_l_i,
	input  logic                          audio_r_i,
	input  logic                          sig_ok_i,     // Signature intact in memory
	input  logic                          zero_check_i, // RAM read-back sweep running
	input  logic                          audio_win_i,  // Count ones on audio_l
	output int                            errors_o,
	output int                            checks_o
);
	import lm80c_pkg::*;

	int errors = 0;
	int checks = 0;
	// Decoder model
	logic [3:0] grp_q;
	logic io_q, wr_n_q;
	logic [7:0] exp_din;
	logic exp_csr_n, exp_csw_n;
	// Eraser model
	logic e_trig_q, e_busy;
	logic [15:0] e_addr;
	int e_writes;
	// Boot checker model
	logic c_busy, c_done, c_led, c_end;
	logic [15:0] c_addr;
	int c_hits;
	// Audio and misc
	logic din0_q, rst_q, win_q;
	int ones;

	assign errors_o = errors;
	assign checks_o = checks;

	function automatic logic [7:0] signature_byte(input int k);
		return SIG_BYTES[(SIG_LEN-1-k)*DATA_W +: DATA_W];
	endfunction

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	always @(posedge CLOCK) begin
		logic [15:0] x_addr;
		logic [7:0] x_wdata;
		logic x_we, x_re, led_wr, led_old, e_start;
		int target;
		if (reset_i) begin
			io_q = 1'b0; grp_q = '0; wr_n_q = 1'b1;
			exp_din = '0; exp_csr_n = 1'b1; exp_csw_n = 1'b1;
			e_trig_q = 1'b0; e_busy = 1'b0; e_writes = 0;
			c_busy = 1'b0; c_done = 1'b0; c_led = 1'b0; c_end = 1'b0;
			c_addr = 16'hFFFF; c_hits = 0;
			rst_q = 1'b1; win_q = 1'b0; ones = 0;
		end else begin
			// Registered outputs against last cycle's prediction
			expect_eq(cpu_din_i, exp_din, "cpu_din_o");
			expect_eq(vdp_csr_n_i, exp_csr_n, "vdp_csr_n_o");
			expect_eq(vdp_csw_n_i, exp_csw_n, "vdp_csw_n_o");
			expect_eq(led_n_i, !c_led, "led_n_o");
			if (c_end)
				expect_eq(led_n_i, !sig_ok_i, "led_n_o after boot check");
			c_end = 1'b0;
			if (!rst_q)
				expect_eq(audio_r_i, audio_l_i ^ din0_q, "audio_r_o");
			// Memory port ownership, fixed priority
			if (dl_active_i) begin
				x_addr = dl_addr_i; x_wdata = dl_data_i; x_we = dl_wr_i; x_re = 1'b1;
			end else if (e_busy) begin
				x_addr = e_addr; x_wdata = '0; x_we = 1'b1; x_re = 1'b1;
			end else if (c_busy) begin
				x_addr = c_addr; x_wdata = '0; x_we = 1'b0; x_re = 1'b1;
			end else begin
				x_addr  = cpu_addr_i;
				x_wdata = cpu_dout_i;
				x_we    = !cpu_wr_n_i && !cpu_mreq_n_i && cpu_addr_i >= RAM_BASE;
				x_re    = !cpu_rd_n_i && !cpu_mreq_n_i;
			end
			expect_eq(mem_addr_i, x_addr, "mem_addr_o");
			expect_eq(mem_we_i, x_we, "mem_we_o");
			expect_eq(mem_re_i, x_re, "mem_re_o");
			if (x_we)
				expect_eq(mem_wdata_i, x_wdata, "mem_wdata_o");
			expect_eq(cpu_wait_i, !boot_done_i || dl_active_i || e_busy || c_busy, "cpu_wait_o");
			expect_eq(cpu_reset_n_i, boot_done_i && !reset_key_i, "cpu_reset_n_o");
			if (e_busy && !dl_active_i && mem_we_i && mem_addr_i == e_addr && mem_wdata_i == 0)
				e_writes++;
			// RAM must read back as zero after the erase
			if (zero_check_i && !dl_active_i && !e_busy && !c_busy && mem_re_i && mem_addr_i[15])
				expect_eq(mem_rdata_i, 0, "erased RAM byte");
			// Duty cycle over the audio window
			if (audio_win_i) begin
				ones += audio_l_i;
				win_q = 1'b1;
			end else if (win_q) begin
				target = ((int'(chan_a_i) + int'(chan_b_i) + int'(chan_c_i)) * 64 * 4096) / 65536;
				checks++;
				if (ones > target + 1 || ones < target - 1) begin
					errors++;
					$display("Mismatch at %0t: audio_l ones %0d, expected %0d", $time, ones, target);
				end
				ones = 0;
				win_q = 1'b0;
			end
			// Decoder prediction for the next sample
			led_wr    = io_q && grp_q == IO_GRP_LED && !cpu_wr_n_i && wr_n_q;
			exp_csr_n = cpu_rd_n_i || cpu_iorq_n_i || !(io_q && grp_q == IO_GRP_VDP);
			exp_csw_n = cpu_wr_n_i || cpu_iorq_n_i || !(io_q && grp_q == IO_GRP_VDP);
			if (io_q && grp_q == IO_GRP_PIO)      exp_din = '0;
			else if (io_q && grp_q == IO_GRP_CTC) exp_din = ctc_data_i;
			else if (io_q && grp_q == IO_GRP_SIO) exp_din = '0;
			else if (io_q && grp_q == IO_GRP_VDP) exp_din = vdp_data_i;
			else if (io_q && grp_q == IO_GRP_PSG) exp_din = psg_data_i;
			else                                  exp_din = mem_rdata_i;
			io_q   = cpu_mreq_n_i && !cpu_iorq_n_i;
			grp_q  = cpu_addr_i[7:4];
			wr_n_q = cpu_wr_n_i;
			// Eraser sweep
			e_start  = erase_trigger_i && !e_trig_q && !e_busy;
			e_trig_q = erase_trigger_i;
			if (e_start) begin
				e_busy = 1'b1;
				e_addr = ERASE_FIRST;
				e_writes = 0;
			end else if (e_busy) begin
				if (e_addr == ERASE_LAST) begin
					e_busy = 1'b0;
					expect_eq(e_writes, 32768, "erase write count");
				end
				e_addr++;
			end
			// Signature check and LED
			led_old = c_led;
			if (!cpu_reset_n_i) begin
				c_busy = 1'b0; c_done = 1'b0; c_led = 1'b0; c_addr = 16'hFFFF; c_hits = 0;
			end else begin
				if (!c_done) begin
					if (c_hits == SIG_LEN)
						c_led = 1'b1;
					if (c_busy && c_addr < SIG_LEN && mem_rdata_i == signature_byte(int'(c_addr)))
						c_hits++;
					if (c_addr == SIG_LEN) begin
						c_busy = 1'b0;
						c_done = 1'b1;
						c_end  = 1'b1;
					end else
						c_busy = 1'b1;
					c_addr++;
				end
				if (led_wr && cpu_dout_i[0])
					c_led = !led_old; // Toggle wins over the set
			end
			din0_q = cpu_din_i[0];
			rst_q  = 1'b0;
		end
	end

endmodule

/* tb/glue_sva.sv */
// Arbiter and eraser assertions
`timescale 1ns/1ps

module glue_sva (
	input logic                          CLOCK,
	input logic                          reset_i,
	input logic                          erase_busy_i,
	input logic [lm80c_pkg::ADDR_W-1:0] erase_addr_i,
	input logic                          dl_active_i,
	input logic [lm80c_pkg::ADDR_W-1:0] mem_addr_i,
	input logic [lm80c_pkg::DATA_W-1:0] mem_wdata_i,
	input logic                          mem_we_i
);
	import lm80c_pkg::*;

	// Sweep starts at the bottom of RAM
	a_erase_first: assert property (@(posedge CLOCK) disable iff (reset_i)
		$rose(erase_busy_i) |-> erase_addr_i == ERASE_FIRST)
		else $error("eraser did not start at the first RAM address");

	// Sweep steps by one
	a_erase_step: assert property (@(posedge CLOCK) disable iff (reset_i)
		(erase_busy_i && $past(erase_busy_i)) |-> erase_addr_i == $past(erase_addr_i) + 16'd1)
		else $error("eraser address skipped");

	// Busy drops right after the top address
	a_erase_end: assert property (@(posedge CLOCK) disable iff (reset_i)
		(erase_busy_i && erase_addr_i == ERASE_LAST) |=> !erase_busy_i)
		else $error("eraser ran past the last address");

	// Eraser owns the port unless a download runs
	a_erase_port: assert property (@(posedge CLOCK) disable iff (reset_i)
		(erase_busy_i && !dl_active_i) |->
		(mem_addr_i == erase_addr_i && mem_we_i && mem_wdata_i == '0))
		else $error("eraser did not own the memory port");

endmodule

bind lm80c_glue glue_sva glue_sva_i (
	.CLOCK         (CLOCK),
	.reset_i       (reset_i),
	.erase_busy_i  (erase_busy),
	.erase_addr_i  (erase_addr),
	.dl_active_i   (dl_active_i),
	.mem_addr_i    (mem_addr_o),
	.mem_wdata_i   (mem_wdata_o),
	.mem_we_i      (mem_we_o)
);

/* src/lm80c_glue.sv */
// LM80C glue top level
`timescale 1ns/1ps

module lm80c_glue (
	input  logic                          CLOCK,
	input  logic                          reset_i,
	// CPU bus
	input  logic [lm80c_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] cpu_dout_i,
	input  logic                          cpu_rd_n_i,
	input  logic                          cpu_wr_n_i,
	input  logic                          cpu_mreq_n_i,
	input  logic                          cpu_iorq_n_i,
	output logic [lm80c_pkg::DATA_W-1:0] cpu_din_o,
	output logic                          cpu_wait_o,
	output logic                          cpu_reset_n_o,
	// Peripheral read data and video strobes
	input  logic [lm80c_pkg::DATA_W-1:0] ctc_data_i,
	input  logic [lm80c_pkg::DATA_W-1:0] vdp_data_i,
	input  logic [lm80c_pkg::DATA_W-1:0] psg_data_i,
	output logic                          vdp_csr_n_o,
	output logic                          vdp_csw_n_o,
	// ROM download
	input  logic                          dl_active_i,
	input  logic                          dl_wr_i,
	input  logic [lm80c_pkg::ADDR_W-1:0] dl_addr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] dl_data_i,
	input  logic                          boot_done_i,
	input  logic                          erase_trigger_i,
	input  logic                          reset_key_i,
	// External memory port
	output logic [lm80c_pkg::ADDR_W-1:0] mem_addr_o,
	output logic [lm80c_pkg::DATA_W-1:0] mem_wdata_o,
	output logic                          mem_we_o,
	output logic                          mem_re_o,
	input  logic [lm80c_pkg::DATA_W-1:0] mem_rdata_i,
	// LED and audio
	output logic                          led_n_o,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_a_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_b_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_c_i,
	output logic                          audio_l_o,
	output logic                          audio_r_o
);
	import lm80c_pkg::*;

	logic              led_wr;      // CPU write to port 0x7x
	logic              erase_busy;
	logic              erase_we;
	logic [ADDR_W-1:0] erase_addr;
	logic              check_busy;
	logic [ADDR_W-1:0] check_addr;

	io_decoder io_decoder_i (
		.CLOCK        (CLOCK),
		.reset_i      (reset_i),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_rd_n_i   (cpu_rd_n_i),
		.cpu_wr_n_i   (cpu_wr_n_i),
		.cpu_mreq_n_i (cpu_mreq_n_i),
		.cpu_iorq_n_i (cpu_iorq_n_i),
		.ctc_data_i   (ctc_data_i),
		.vdp_data_i   (vdp_data_i),
		.psg_data_i   (psg_data_i),
		.mem_rdata_i  (mem_rdata_i),
		.cpu_din_o    (cpu_din_o),
		.vdp_csr_n_o  (vdp_csr_n_o),
		.vdp_csw_n_o  (vdp_csw_n_o),
		.led_wr_o     (led_wr)
	);

	mem_arbiter mem_arbiter_i (
		.dl_active_i   (dl_active_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.erase_busy_i  (erase_busy),
		.erase_we_i    (erase_we),
		.erase_addr_i  (erase_addr),
		.check_busy_i  (check_busy),
		.check_addr_i  (check_addr),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_dout_i    (cpu_dout_i),
		.cpu_rd_n_i    (cpu_rd_n_i),
		.cpu_wr_n_i    (cpu_wr_n_i),
		.cpu_mreq_n_i  (cpu_mreq_n_i),
		.boot_done_i   (boot_done_i),
		.reset_key_i   (reset_key_i),
		.mem_addr_o    (mem_addr_o),
		.mem_wdata_o   (mem_wdata_o),
		.mem_we_o      (mem_we_o),
		.mem_re_o      (mem_re_o),
		.cpu_wait_o    (cpu_wait_o),
		.cpu_reset_n_o (cpu_reset_n_o)
	);

	ram_eraser ram_eraser_i (
		.CLOCK     (CLOCK),
		.reset_i   (reset_i),
		.trigger_i (erase_trigger_i),
		.busy_o    (erase_busy),
		.we_o      (erase_we),
		.addr_o    (erase_addr)
	);

	boot_checker boot_checker_i (
		.CLOCK         (CLOCK),
		.reset_i       (reset_i),
		.cpu_reset_n_i (cpu_reset_n_o), // Check reruns after each CPU reset
		.mem_rdata_i   (mem_rdata_i),
		.led_wr_i      (led_wr),
		.cpu_dout_i    (cpu_dout_i),
		.busy_o        (check_busy),
		.addr_o        (check_addr),
		.led_n_o       (led_n_o)
	);

	audio_mixer audio_mixer_i (
		.CLOCK     (CLOCK),
		.reset_i   (reset_i),
		.chan_a_i  (chan_a_i),
		.chan_b_i  (chan_b_i),
		.chan_c_i  (chan_c_i),
		.din_bit_i (cpu_din_o[0]),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

endmodule

/* src/audio_mixer.sv */
// Audio mixer and sigma-delta DAC
`timescale 1ns/1ps

module audio_mixer #(
	parameter int DAC_W = lm80c_pkg::AUDIO_W
) (
	input  logic                          CLOCK,
	input  logic                          reset_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_a_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_b_i,
	input  logic [lm80c_pkg::DATA_W-1:0] chan_c_i,
	input  logic                          din_bit_i,
	output logic                          audio_l_o,
	output logic                          audio_r_o
);

	logic [$bits(chan_a_i)+1:0] sum_q;  // Three channels need two extra bits
	logic [DAC_W-1:0]           dac_in;
	logic [DAC_W:0]             acc;    // Top bit is the carry out

	// Channel sum
	always_ff @(posedge CLOCK) begin
		if (reset_i)
			sum_q <= '0;
		else
			sum_q <= {2'b00, chan_a_i} + {2'b00, chan_b_i} + {2'b00, chan_c_i};
	end

	// Left aligned into DAC range
	assign dac_in = {sum_q, {(DAC_W-$bits(sum_q)){1'b0}}};

	// First order modulator, carry drops back out each cycle
	always_ff @(posedge CLOCK) begin
		if (reset_i)
			acc <= '0;
		else
			acc <= {1'b0, acc[DAC_W-1:0]} + {1'b0, dac_in};
	end

	// Output pins
	always_ff @(posedge CLOCK) begin
		if (reset_i) begin
			audio_l_o <= 1'b0;
			audio_r_o <= 1'b0;
		end else begin
			audio_l_o <= acc[DAC_W];
			audio_r_o <= acc[DAC_W] ^ din_bit_i; // Speaker bit from CPU data
		end
	end

endmodule

/* memory/boot_checker.sv */
// Boot signature checker and debug LED
`timescale 1ns/1ps

module boot_checker (
	input  logic                          CLOCK,
	input  logic                          reset_i,
	input  logic                          cpu_reset_n_i,
	input  logic [lm80c_pkg::DATA_W-1:0] mem_rdata_i,
	input  logic                          led_wr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] cpu_dout_i,
	output logic                          busy_o,
	output logic [lm80c_pkg::ADDR_W-1:0] addr_o,
	output logic                          led_n_o
);
	import lm80c_pkg::*;

	logic                         done;     // Sweep finished
	logic                         led_on;
	logic [$clog2(SIG_LEN+1)-1:0] hits;     // Matching bytes so far
	logic [DATA_W-1:0]            sig_byte; // Expected byte at addr_o
	logic                         hit;

	// Pick signature byte for current address
	always_comb begin
		sig_byte = '0;
		for (int k = 0; k < SIG_LEN; k++) begin
			if (addr_o == ADDR_W'(k))
				sig_byte = SIG_BYTES[(SIG_LEN-1-k)*DATA_W +: DATA_W];
		end
	end

	assign hit = busy_o && (addr_o < ADDR_W'(SIG_LEN)) && (mem_rdata_i == sig_byte);

	always_ff @(posedge CLOCK) begin
		if (reset_i || !cpu_reset_n_i) begin
			busy_o <= 1'b0;
			addr_o <= '1; // Wraps to 0 on first step
			hits   <= '0;
			done   <= 1'b0;
			led_on <= 1'b0;
		end else begin
			if (!done) begin
				busy_o <= 1'b1;
				addr_o <= addr_o + 1'b1;
				if (hit)
					hits <= hits + 1'b1;
				if (addr_o == ADDR_W'(SIG_LEN)) begin
					busy_o <= 1'b0;
					done   <= 1'b1;
				end
				if (hits == SIG_LEN)
					led_on <= 1'b1; // Full signature seen
			end
			// CPU toggle on port 0x7x
			if (led_wr_i && cpu_dout_i[0])
				led_on <= ~led_on;
		end
	end

	assign led_n_o = ~led_on; // Pin is active low

endmodule

/* memory/ram_eraser.sv */
// RAM eraser
`timescale 1ns/1ps

module ram_eraser (
	input  logic                          CLOCK,
	input  logic                          reset_i,
	input  logic                          trigger_i,
	output logic                          busy_o,
	output logic                          we_o,
	output logic [lm80c_pkg::ADDR_W-1:0] addr_o
);
	import lm80c_pkg::*;

	logic trig_q; // Trigger level one cycle back
	logic start;

	assign start = trigger_i & ~trig_q & ~busy_o; // Edges while busy are dropped

	always_ff @(posedge CLOCK) begin
		if (reset_i) begin
			trig_q <= 1'b0;
			busy_o <= 1'b0;
		end else begin
			trig_q <= trigger_i;
			if (start)
				busy_o <= 1'b1;
			else if (busy_o && addr_o == ERASE_LAST)
				busy_o <= 1'b0; // Last write done
		end
	end

	// Sweep pointer
	always_ff @(posedge CLOCK) begin
		if (start)
			addr_o <= ERASE_FIRST;
		else if (busy_o)
			addr_o <= addr_o + 1'b1;
	end

	assign we_o = busy_o; // One write per busy cycle

endmodule

/* memory/mem_arbiter.sv */
// Memory port arbiter
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                          dl_active_i,
	input  logic                          dl_wr_i,
	input  logic [lm80c_pkg::ADDR_W-1:0] dl_addr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] dl_data_i,
	input  logic                          erase_busy_i,
	input  logic                          erase_we_i,
	input  logic [lm80c_pkg::ADDR_W-1:0] erase_addr_i,
	input  logic                          check_busy_i,
	input  logic [lm80c_pkg::ADDR_W-1:0] check_addr_i,
	input  lm80c_pkg::bus_addr_u          cpu_addr_i,
	input  logic [lm80c_pkg::DATA_W-1:0] cpu_dout_i,
	input  logic                          cpu_rd_n_i,
	input  logic                          cpu_wr_n_i,
	input  logic                          cpu_mreq_n_i,
	input  logic                          boot_done_i,
	input  logic                          reset_key_i,
	output logic [lm80c_pkg::ADDR_W-1:0] mem_addr_o,
	output logic [lm80c_pkg::DATA_W-1:0] mem_wdata_o,
	output logic                          mem_we_o,
	output logic                          mem_re_o,
	output logic                          cpu_wait_o,
	output logic                          cpu_reset_n_o
);
	import lm80c_pkg::*;

	// Fixed priority, downloader first and CPU last
	always_comb begin
		if (dl_active_i) begin
			mem_addr_o  = dl_addr_i;
			mem_wdata_o = dl_data_i;
			mem_we_o    = dl_wr_i;
			mem_re_o    = 1'b1;
		end else if (erase_busy_i) begin
			mem_addr_o  = erase_addr_i;
			mem_wdata_o = '0;              // Eraser only writes zeros
			mem_we_o    = erase_we_i;
			mem_re_o    = 1'b1;
		end else if (check_busy_i) begin
			mem_addr_o  = check_addr_i;
			mem_wdata_o = '0;
			mem_we_o    = 1'b0;            // Checker reads only
			mem_re_o    = 1'b1;
		end else begin
			mem_addr_o  = cpu_addr_i;
			mem_wdata_o = cpu_dout_i;
			// ROM half stays write protected
			mem_we_o    = ~cpu_wr_n_i & ~cpu_mreq_n_i & cpu_addr_i.mem.ram;
			mem_re_o    = ~cpu_rd_n_i & ~cpu_mreq_n_i;
		end
	end

	// Hold CPU while booting or while someone else owns memory
	assign cpu_wait_o = ~boot_done_i | dl_active_i | erase_busy_i | check_busy_i;

	// Reset until ROM loaded, or on the reset key
	assign cpu_reset_n_o = boot_done_i & ~reset_key_i;

endmodule

/* src/io_decoder.sv */
// I/O address decoder and read mux
`timescale 1ns/1ps

module io_decoder (
	input  logic                          CLOCK,
	input  logic                          reset_i,
	input  lm80c_pkg::bus_addr_u          cpu_addr_i,
	input  logic                          cpu_rd_n_i,
	input  logic                          cpu_wr_n_i,
	input  logic                          cpu_mreq_n_i,
	input  logic                          cpu_iorq_n_i,
	input  logic [lm80c_pkg::DATA_W-1:0] ctc_data_i,
	input  logic [lm80c_pkg::DATA_W-1:0] vdp_data_i,
	input  logic [lm80c_pkg::DATA_W-1:0] psg_data_i,
	input  logic [lm80c_pkg::DATA_W-1:0] mem_rdata_i,
	output logic [lm80c_pkg::DATA_W-1:0] cpu_din_o,
	output logic                          vdp_csr_n_o,
	output logic                          vdp_csw_n_o,
	output logic                          led_wr_o
);
	import lm80c_pkg::*;

	logic io_cyc;   // MREQ high with IORQ low
	logic pio_sel, ctc_sel, sio_sel, vdp_sel, psg_sel, led_sel;
	logic wr_n_q;   // Last cycle's WR level

	assign io_cyc = cpu_mreq_n_i & ~cpu_iorq_n_i;

	// Group selects, one cycle behind the bus
	always_ff @(posedge CLOCK) begin
		if (reset_i) begin
			pio_sel <= 1'b0;
			ctc_sel <= 1'b0;
			sio_sel <= 1'b0;
			vdp_sel <= 1'b0;
			psg_sel <= 1'b0;
			led_sel <= 1'b0;
			wr_n_q  <= 1'b1;
		end else begin
			pio_sel <= io_cyc && (cpu_addr_i.io.grp == IO_GRP_PIO);
			ctc_sel <= io_cyc && (cpu_addr_i.io.grp == IO_GRP_CTC);
			sio_sel <= io_cyc && (cpu_addr_i.io.grp == IO_GRP_SIO);
			vdp_sel <= io_cyc && (cpu_addr_i.io.grp == IO_GRP_VDP);
			psg_sel <= io_cyc && (cpu_addr_i.io.grp == IO_GRP_PSG);
			led_sel <= io_cyc && (cpu_addr_i.io.grp == IO_GRP_LED);
			wr_n_q  <= cpu_wr_n_i;
		end
	end

	// VDP strobes and read mux, from the registered selects
	always_ff @(posedge CLOCK) begin
		if (reset_i) begin
			vdp_csr_n_o <= 1'b1;
			vdp_csw_n_o <= 1'b1;
			cpu_din_o   <= '0;
		end else begin
			vdp_csr_n_o <= cpu_rd_n_i | cpu_iorq_n_i | ~vdp_sel;
			vdp_csw_n_o <= cpu_wr_n_i | cpu_iorq_n_i | ~vdp_sel;
			if (pio_sel)      cpu_din_o <= '0;          // PIO not fitted
			else if (ctc_sel) cpu_din_o <= ctc_data_i;
			else if (sio_sel) cpu_din_o <= '0;          // SIO not fitted
			else if (vdp_sel) cpu_din_o <= vdp_data_i;
			else if (psg_sel) cpu_din_o <= psg_data_i;
			else              cpu_din_o <= mem_rdata_i; // ROM or RAM
		end
	end

	// Single pulse on the WR falling edge
	assign led_wr_o = led_sel & ~cpu_wr_n_i & wr_n_q;

endmodule

/* common/lm80c_pkg.sv */
// LM80C glue shared definitions
package lm80c_pkg;

	// Bus widths
	localparam int ADDR_W = 16; // Z80 address bus
	localparam int DATA_W = 8;  // Z80 data bus

	// I/O groups, selected by address bits 7..4
	localparam logic [3:0] IO_GRP_PIO = 4'd0;
	localparam logic [3:0] IO_GRP_CTC = 4'd1;
	localparam logic [3:0] IO_GRP_SIO = 4'd2;
	localparam logic [3:0] IO_GRP_VDP = 4'd3;
	localparam logic [3:0] IO_GRP_PSG = 4'd4;
	localparam logic [3:0] IO_GRP_LED = 4'd7; // Debug LED, port 0x70

	// Memory map, upper half is RAM
	localparam logic [ADDR_W-1:0] RAM_BASE = 16'h8000;

	// Eraser sweep range
	localparam logic [ADDR_W-1:0] ERASE_FIRST = RAM_BASE;
	localparam logic [ADDR_W-1:0] ERASE_LAST  = 16'hFFFF;

	// ROM signature at address 0, first byte on top
	localparam int SIG_LEN = 4;
	localparam logic [SIG_LEN*DATA_W-1:0] SIG_BYTES = 32'hF3C35A02;

	// Sigma-delta input width
	localparam int AUDIO_W = 16;

	// One bus word, seen as I/O port or as memory address
	typedef union packed {
		struct packed {
			logic [7:0] unused;  // High byte, ignored on I/O
			logic [3:0] grp;     // Device group
			logic [1:0] spare;
			logic [1:0] reg_idx; // Register inside the device
		} io;
		struct packed {
			logic        ram;    // Bit 15 set means RAM
			logic [14:0] offset;
		} mem;
	} bus_addr_u;

endpackage
